/* memsys_settings.svh */
`ifndef MEMSYS_SETTINGS_SVH
`define MEMSYS_SETTINGS_SVH

// Cache geometry, one word per line
`define I_LINES 16
`define D_LINES 16

// Bus memory depth in words
`define MEM_WORDS 256

// Cycles from first request cycle to ready
`define MEM_WAIT 3

// Value returned on a read of the ID register
`define CP15_ID 32'h4107_0A10

`endif

/* memsysPkg.sv */
package memsysPkg;

  // One bus request, held until ready
  typedef struct packed {
    logic        req;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wData;
    logic [3:0]  mask;
  } busReqT;

  typedef struct packed {
    logic        ready;
    logic [31:0] rData;
  } busRespT;

  // Core side ports, byte addresses
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } fetchReqT;

  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wData;
    logic [3:0]  mask;
  } dataReqT;

  // MCR/MRC style access, CRn selects the register
  typedef struct packed {
    logic        en;
    logic        write;
    logic [3:0]  crn;
    logic [2:0]  op2;
    logic [3:0]  crm;
    logic [31:0] wData;
  } cpReqT;

  typedef enum logic [1:0] {LOOKUP, FILL, WRITE} cacheStateT;
  typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_DATA} busOwnerT;

  typedef enum logic [3:0] {
    REG_ID      = 4'd0,
    REG_CONTROL = 4'd1,
    REG_TBASE   = 4'd2,
    REG_CACHEOP = 4'd7
  } cpRegT;

  typedef enum logic [3:0] {
    OP_INV_I    = 4'd5,
    OP_INV_D    = 4'd6,
    OP_INV_BOTH = 4'd7
  } cacheOpT;

  // Replace only the bytes selected by the mask
  function automatic logic [31:0] mergeBytes(
    input logic [31:0] oldWord,
    input logic [31:0] newWord,
    input logic [3:0]  mask
  );
    logic [31:0] result;
    result = oldWord;
    for (int b = 0; b < 4; b++)
    begin
      if (mask[b])
      begin
        result[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

/* sysControl.sv */
`timescale 1ns/1ps
`include "memsys_settings.svh"

module sysControl (
  input  logic              clk,
  input  logic              rstN,
  input  memsysPkg::cpReqT  cpReq,
  output logic [31:0]       cpRd,
  output logic              iEnable,
  output logic              dEnable,
  output logic              invI,
  output logic              invD
);
  import memsysPkg::*;

  logic [31:0] controlReg;
  logic [31:0] tBaseReg;
  cpRegT       regSel;
  cacheOpT     opSel;
  logic        wrEn;

  assign regSel = cpRegT'(cpReq.crn);
  assign opSel  = cacheOpT'(cpReq.crm);
  assign wrEn   = cpReq.en & cpReq.write;

  // I bit and C bit of the control register
  assign iEnable = controlReg[12];
  assign dEnable = controlReg[2];

  always_comb
  begin
    cpRd = '0;
    if (cpReq.en)
    begin
      case (regSel)
        REG_ID:      cpRd = `CP15_ID;
        REG_CONTROL: cpRd = controlReg;
        REG_TBASE:   cpRd = tBaseReg;
        default:     cpRd = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      controlReg <= '0;
      tBaseReg   <= '0;
      invI       <= 1'b0;
      invD       <= 1'b0;
    end
    else
    begin
      // Pulses last a single cycle
      invI <= 1'b0;
      invD <= 1'b0;
      if (wrEn)
      begin
        case (regSel)
          REG_CONTROL: controlReg <= cpReq.wData;
          REG_TBASE:   tBaseReg <= cpReq.wData;
          REG_CACHEOP:
          begin
            // c7 ops with opcode2 of 0 invalidate whole caches
            if (cpReq.op2 == 3'd0)
            begin
              invI <= (opSel == OP_INV_I) || (opSel == OP_INV_BOTH);
              invD <= (opSel == OP_INV_D) || (opSel == OP_INV_BOTH);
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* instrCache.sv */
`timescale 1ns/1ps
`include "memsys_settings.svh"

module instrCache (
  input  logic                clk,
  input  logic                rstN,
  input  logic                enable,
  input  logic                invalidate,
  input  memsysPkg::fetchReqT fetchReq,
  output logic [31:0]         instr,
  output logic                iStall,
  output memsysPkg::busReqT   busReq,
  input  memsysPkg::busRespT  busResp
);
  import memsysPkg::*;

  localparam int IDX_W = $clog2(`I_LINES);
  localparam int TAG_W = 30 - IDX_W;

  logic [TAG_W-1:0]    tagArr [`I_LINES];
  logic [31:0]         dataArr [`I_LINES];
  logic [`I_LINES-1:0] validBits;
  cacheStateT          state;
  logic [IDX_W-1:0]    idx;
  logic [TAG_W-1:0]    tag;
  logic                hit;
  logic                fillDone;

  assign idx = fetchReq.addr[IDX_W+1:2];
  assign tag = fetchReq.addr[31:IDX_W+2];
  assign hit = enable & validBits[idx] & (tagArr[idx] == tag);
  assign fillDone = (state == FILL) & busResp.ready;

  // Miss data comes straight from the bus in the ready cycle
  assign instr  = (state == FILL) ? busResp.rData : dataArr[idx];
  assign iStall = (state == LOOKUP) ? (fetchReq.valid & ~hit) : ~busResp.ready;

  assign busReq.req   = (state == FILL);
  assign busReq.write = 1'b0;
  assign busReq.addr  = {2'b00, fetchReq.addr[31:2]};
  assign busReq.wData = '0;
  assign busReq.mask  = 4'hF;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state     <= LOOKUP;
      validBits <= '0;
    end
    else
    begin
      if (state == LOOKUP && fetchReq.valid && !hit)
        state <= FILL;
      else if (fillDone)
        state <= LOOKUP;

      // Invalidate wins over a fill in the same cycle
      if (invalidate)
        validBits <= '0;
      else if (fillDone && enable)
        validBits[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fillDone && enable)
    begin
      tagArr[idx]  <= tag;
      dataArr[idx] <= busResp.rData;
    end
  end

endmodule

/* dataCache.sv */
`timescale 1ns/1ps
`include "memsys_settings.svh"

module dataCache (
  input  logic               clk,
  input  logic               rstN,
  input  logic               enable,
  input  logic               invalidate,
  input  memsysPkg::dataReqT dataReq,
  output logic [31:0]        rdata,
  output logic               dStall,
  output memsysPkg::busReqT  busReq,
  input  memsysPkg::busRespT busResp
);
  import memsysPkg::*;

  localparam int IDX_W = $clog2(`D_LINES);
  localparam int TAG_W = 30 - IDX_W;

  logic [TAG_W-1:0]    tagArr [`D_LINES];
  logic [31:0]         dataArr [`D_LINES];
  logic [`D_LINES-1:0] validBits;
  cacheStateT          state;
  logic [IDX_W-1:0]    idx;
  logic [TAG_W-1:0]    tag;
  logic                hit;
  logic                fillDone;
  logic                writeDone;
  logic [31:0]         mergedWord;

  assign idx = dataReq.addr[IDX_W+1:2];
  assign tag = dataReq.addr[31:IDX_W+2];
  assign hit = enable & validBits[idx] & (tagArr[idx] == tag);

  assign fillDone   = (state == FILL) & busResp.ready;
  assign writeDone  = (state == WRITE) & busResp.ready;
  assign mergedWord = mergeBytes(dataArr[idx], dataReq.wData, dataReq.mask);

  assign rdata = (state == FILL) ? busResp.rData : dataArr[idx];

  // Writes always stall, reads only on a miss
  always_comb
  begin
    if (state == LOOKUP)
      dStall = dataReq.write | (dataReq.read & ~hit);
    else
      dStall = ~busResp.ready;
  end

  assign busReq.req   = (state != LOOKUP);
  assign busReq.write = (state == WRITE);
  assign busReq.addr  = {2'b00, dataReq.addr[31:2]};
  assign busReq.wData = dataReq.wData;
  assign busReq.mask  = (state == WRITE) ? dataReq.mask : 4'hF;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state     <= LOOKUP;
      validBits <= '0;
    end
    else
    begin
      case (state)
        LOOKUP:
        begin
          if (dataReq.write)
            state <= WRITE;
          else if (dataReq.read && !hit)
            state <= FILL;
        end
        default:
        begin
          if (busResp.ready)
            state <= LOOKUP;
        end
      endcase

      if (invalidate)
        validBits <= '0;
      else if (fillDone && enable)
        validBits[idx] <= 1'b1;
    end
  end

  // Write miss leaves the cache untouched
  always_ff @(posedge clk)
  begin
    if (fillDone && enable)
    begin
      tagArr[idx]  <= tag;
      dataArr[idx] <= busResp.rData;
    end
    else if (writeDone && hit)
    begin
      dataArr[idx] <= mergedWord;
    end
  end

endmodule

/* busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic               clk,
  input  logic               rstN,
  input  memsysPkg::busReqT  fetchBusReq,
  input  memsysPkg::busReqT  dataBusReq,
  output memsysPkg::busRespT fetchBusResp,
  output memsysPkg::busRespT dataBusResp,
  output memsysPkg::busReqT  memReq,
  input  memsysPkg::busRespT memResp
);
  import memsysPkg::*;

  busOwnerT owner;
  busOwnerT grant;

  // A new grant is given only while idle, data side first
  always_comb
  begin
    grant = owner;
    if (owner == OWN_NONE)
    begin
      if (dataBusReq.req)
        grant = OWN_DATA;
      else if (fetchBusReq.req)
        grant = OWN_FETCH;
    end
  end

  always_comb
  begin
    case (grant)
      OWN_DATA:  memReq = dataBusReq;
      OWN_FETCH: memReq = fetchBusReq;
      default:   memReq = '0;
    endcase
  end

  assign fetchBusResp.ready = memResp.ready & (grant == OWN_FETCH);
  assign fetchBusResp.rData = memResp.rData;
  assign dataBusResp.ready  = memResp.ready & (grant == OWN_DATA);
  assign dataBusResp.rData  = memResp.rData;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      owner <= OWN_NONE;
    else if (memResp.ready)
      owner <= OWN_NONE;
    else
      owner <= grant;
  end

endmodule

/* busMemory.sv */
`timescale 1ns/1ps
`include "memsys_settings.svh"

module busMemory (
  input  logic               clk,
  input  logic               rstN,
  input  memsysPkg::busReqT  memReq,
  output memsysPkg::busRespT memResp
);
  import memsysPkg::*;

  localparam int IDX_W  = $clog2(`MEM_WORDS);
  localparam int WAIT   = `MEM_WAIT;
  localparam int CNT_W  = $clog2(WAIT + 1);

  logic [31:0]      mem [`MEM_WORDS];
  logic [IDX_W-1:0] wordIdx;
  logic [CNT_W-1:0] waitCnt;

  // Word address, upper bits ignored
  assign wordIdx = memReq.addr[IDX_W-1:0];

  assign memResp.ready = memReq.req & (waitCnt == CNT_W'(WAIT));
  assign memResp.rData = mem[wordIdx];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      waitCnt <= '0;
    else if (memResp.ready)
      waitCnt <= '0;
    else if (memReq.req)
      waitCnt <= waitCnt + 1'b1;
  end

  // Write commits at the end of the ready cycle
  always_ff @(posedge clk)
  begin
    if (memResp.ready && memReq.write)
      mem[wordIdx] <= mergeBytes(mem[wordIdx], memReq.wData, memReq.mask);
  end

endmodule

/* memsysTop.sv */
`timescale 1ns/1ps

module memsysTop (
  input  logic                clk,
  input  logic                rstN,
  input  memsysPkg::fetchReqT fetchReq,
  output logic [31:0]         instr,
  output logic                iStall,
  input  memsysPkg::dataReqT  dataReq,
  output logic [31:0]         rdata,
  output logic                dStall,
  input  memsysPkg::cpReqT    cpReq,
  output logic [31:0]         cpRd
);
  import memsysPkg::*;

  logic    iEnable, dEnable, invI, invD;
  busReqT  fetchBusReq, dataBusReq, memReq;
  busRespT fetchBusResp, dataBusResp, memResp;

  sysControl sysControl_i (
    .clk     (clk),
    .rstN    (rstN),
    .cpReq   (cpReq),
    .cpRd    (cpRd),
    .iEnable (iEnable),
    .dEnable (dEnable),
    .invI    (invI),
    .invD    (invD)
  );

  instrCache instrCache_i (
    .clk        (clk),
    .rstN       (rstN),
    .enable     (iEnable),
    .invalidate (invI),
    .fetchReq   (fetchReq),
    .instr      (instr),
    .iStall     (iStall),
    .busReq     (fetchBusReq),
    .busResp    (fetchBusResp)
  );

  dataCache dataCache_i (
    .clk        (clk),
    .rstN       (rstN),
    .enable     (dEnable),
    .invalidate (invD),
    .dataReq    (dataReq),
    .rdata      (rdata),
    .dStall     (dStall),
    .busReq     (dataBusReq),
    .busResp    (dataBusResp)
  );

  busArbiter busArbiter_i (
    .clk          (clk),
    .rstN         (rstN),
    .fetchBusReq  (fetchBusReq),
    .dataBusReq   (dataBusReq),
    .fetchBusResp (fetchBusResp),
    .dataBusResp  (dataBusResp),
    .memReq       (memReq),
    .memResp      (memResp)
  );

  busMemory busMemory_i (
    .clk     (clk),
    .rstN    (rstN),
    .memReq  (memReq),
    .memResp (memResp)
  );

endmodule

/* memsys_assert.sv */
`timescale 1ns/1ps
`include "memsys_settings.svh"

module memsysAssert (
  input logic               clk,
  input logic               rstN,
  input logic               iStall,
  input logic               dStall,
  input logic               invI,
  input logic               invD,
  input memsysPkg::busReqT  memReq,
  input memsysPkg::busRespT memResp
);

  int failCount = 0;

  // No request is pending right after reset
  property quietAfterReset;
    @(posedge clk) $rose(rstN) |=> (!iStall && !dStall);
  endproperty

  property invIPulse;
    @(posedge clk) disable iff (!rstN) invI |=> !invI;
  endproperty

  property invDPulse;
    @(posedge clk) disable iff (!rstN) invD |=> !invD;
  endproperty

  // Owner keeps every request field until ready
  property reqHeldUntilReady;
    @(posedge clk) disable iff (!rstN) (memReq.req && !memResp.ready) |=> $stable(memReq);
  endproperty

  // Ready only for a request that has waited the full latency
  property readyAfterWait;
    @(posedge clk) disable iff (!rstN) memResp.ready |-> $past(memReq.req, `MEM_WAIT);
  endproperty

  assert property (quietAfterReset)
  else
  begin
    $error("stall high in the first cycle after reset");
    failCount++;
  end

  assert property (invIPulse)
  else
  begin
    $error("invI stayed high for two cycles");
    failCount++;
  end

  assert property (invDPulse)
  else
  begin
    $error("invD stayed high for two cycles");
    failCount++;
  end

  assert property (reqHeldUntilReady)
  else
  begin
    $error("bus request changed before ready");
    failCount++;
  end

  assert property (readyAfterWait)
  else
  begin
    $error("memory gave ready without a waiting request");
    failCount++;
  end

endmodule

bind memsysTop memsysAssert memsysAssert_i (
  .clk     (clk),
  .rstN    (rstN),
  .iStall  (iStall),
  .dStall  (dStall),
  .invI    (invI),
  .invD    (invD),
  .memReq  (memReq),
  .memResp (memResp)
);

/* memsysTb.sv */
`timescale 1ns/1ps
`include "memsys_settings.svh"

module memsysTb;
  import memsysPkg::*;

  localparam int N_WORDS = 8;
  localparam int N_HOT   = 4;

  // Stall rules for a single access
  localparam int ANY_STALL  = 0;
  localparam int NO_STALL   = 1;
  localparam int MUST_STALL = 2;

  // Accesses per phase, the last two slots cover reset
  localparam int ACCESSES = 3*N_WORDS + 5 + 4*N_HOT + (N_HOT + 1) + (2*N_HOT + 2)
                            + (2*N_HOT + 1) + N_HOT/2 + 2;
  localparam int TIMEOUT_NS = ACCESSES * (`MEM_WAIT + 4) * 100;

  logic        clk;
  logic        rstN;
  fetchReqT    fetchReq;
  logic [31:0] instr;
  logic        iStall;
  dataReqT     dataReq;
  logic [31:0] rdata;
  logic        dStall;
  cpReqT       cpReq;
  logic [31:0] cpRd;

  logic [15:0] lfsr = 16'd31;
  logic [31:0] shadow [`MEM_WORDS];
  logic [7:0]  words [N_WORDS];
  int          checks = 0;
  int          errors = 0;

  memsysTop memsysTop_i (
    .clk      (clk),
    .rstN     (rstN),
    .fetchReq (fetchReq),
    .instr    (instr),
    .iStall   (iStall),
    .dataReq  (dataReq),
    .rdata    (rdata),
    .dStall   (dStall),
    .cpReq    (cpReq),
    .cpRd     (cpRd)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Shadow model of a masked write
  function automatic logic [31:0] applyMask(input logic [31:0] oldWord,
                                            input logic [31:0] newWord,
                                            input logic [3:0] mask);
    logic [31:0] byteSel;
    byteSel = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (newWord & byteSel) | (oldWord & ~byteSel);
  endfunction

  function automatic logic [31:0] byteAddr(input logic [7:0] w);
    return {22'd0, w, 2'b00};
  endfunction

  task automatic checkWord(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkStall(input string what, input logic [31:0] addr,
                            input int stalls, input int rule);
    if (rule != ANY_STALL)
    begin
      checks++;
      assert ((stalls == 0) == (rule == NO_STALL))
      else
      begin
        errors++;
        if (rule == NO_STALL)
          $display("%s of %h at %0t ns stalled %0d cycles on a hit", what, addr, $time, stalls);
        else
          $display("%s of %h at %0t ns did not stall after invalidation", what, addr, $time);
      end
    end
  endtask

  // One data access, held until the stall falls
  task automatic dataAccess(input logic isWrite, input logic [31:0] addr,
                            input logic [31:0] wData, input logic [3:0] mask,
                            output logic [31:0] got, output int stalls);
    dataReqT req;
    req.read  = ~isWrite;
    req.write = isWrite;
    req.addr  = addr;
    req.wData = wData;
    req.mask  = mask;
    stalls = 0;
    @(posedge clk);
    dataReq <= req;
    @(negedge clk);
    while (dStall)
    begin
      stalls++;
      @(negedge clk);
    end
    got = rdata;
    @(posedge clk);
    dataReq <= '0;
  endtask

  task automatic writeWord(input int idx, input logic [31:0] wData, input logic [3:0] mask);
    logic [31:0] got;
    int          stalls;
    shadow[words[idx]] = applyMask(shadow[words[idx]], wData, mask);
    dataAccess(1'b1, byteAddr(words[idx]), wData, mask, got, stalls);
  endtask

  task automatic readWord(input int idx, input int rule);
    logic [31:0] got;
    int          stalls;
    dataAccess(1'b0, byteAddr(words[idx]), 32'd0, 4'h0, got, stalls);
    checkWord("rdata", got, shadow[words[idx]]);
    checkStall("data read", byteAddr(words[idx]), stalls, rule);
  endtask

  task automatic fetchWord(input int idx, input int rule);
    fetchReqT    req;
    logic [31:0] got;
    int          stalls;
    req.valid = 1'b1;
    req.addr  = byteAddr(words[idx]);
    stalls = 0;
    @(posedge clk);
    fetchReq <= req;
    @(negedge clk);
    while (iStall)
    begin
      stalls++;
      @(negedge clk);
    end
    got = instr;
    @(posedge clk);
    fetchReq <= '0;
    checkWord("instr", got, shadow[words[idx]]);
    checkStall("fetch", req.addr, stalls, rule);
  endtask

  task automatic cpWrite(input logic [3:0] crn, input logic [3:0] crm, input logic [31:0] wData);
    cpReqT req;
    req.en    = 1'b1;
    req.write = 1'b1;
    req.crn   = crn;
    req.op2   = 3'd0;
    req.crm   = crm;
    req.wData = wData;
    @(posedge clk);
    cpReq <= req;
    @(posedge clk);
    cpReq <= '0;
  endtask

  task automatic cpRead(input logic [3:0] crn, output logic [31:0] got);
    cpReqT req;
    req       = '0;
    req.en    = 1'b1;
    req.crn   = crn;
    @(posedge clk);
    cpReq <= req;
    @(negedge clk);
    got = cpRd;
    @(posedge clk);
    cpReq <= '0;
  endtask

  // Fetch and data access start in the same cycle
  task automatic dualAccess(input int fIdx, input int dIdx, input logic dWrite);
    fetchReqT    fReq;
    dataReqT     dReq;
    logic [31:0] fGot;
    logic [31:0] dGot;
    logic [31:0] r;
    logic        fDone;
    logic        dDone;
    r = randBits(4);
    fReq.valid = 1'b1;
    fReq.addr  = byteAddr(words[fIdx]);
    dReq.read  = ~dWrite;
    dReq.write = dWrite;
    dReq.addr  = byteAddr(words[dIdx]);
    dReq.wData = randBits(32);
    dReq.mask  = r[3:0];
    if (dWrite)
      shadow[words[dIdx]] = applyMask(shadow[words[dIdx]], dReq.wData, dReq.mask);
    fGot  = '0;
    dGot  = '0;
    fDone = 1'b0;
    dDone = 1'b0;
    @(posedge clk);
    fetchReq <= fReq;
    dataReq  <= dReq;
    while (!(fDone && dDone))
    begin
      @(negedge clk);
      if (!fDone && !iStall)
      begin
        fGot  = instr;
        fDone = 1'b1;
      end
      if (!dDone && !dStall)
      begin
        dGot  = rdata;
        dDone = 1'b1;
      end
      @(posedge clk);
      if (fDone)
        fetchReq <= '0;
      if (dDone)
        dataReq <= '0;
    end
    checkWord("instr", fGot, shadow[words[fIdx]]);
    if (!dWrite)
      checkWord("rdata", dGot, shadow[words[dIdx]]);
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] ctrl;
    logic [31:0] tBase;
    logic [31:0] got;
    rstN     <= 1'b0;
    fetchReq <= '0;
    dataReq  <= '0;
    cpReq    <= '0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    repeat (2) @(posedge clk);

    // Caches off, so every access goes through to memory
    for (int i = 0; i < N_WORDS; i++)
    begin
      r = randBits(5);
      words[i] = {i[2:0], r[4:0]};
      writeWord(i, randBits(32), 4'hF);
    end
    for (int i = 0; i < N_WORDS; i++)
    begin
      r = randBits(3);
      m = randBits(4);
      writeWord(int'(r[2:0]), randBits(32), m[3:0]);
    end
    for (int i = 0; i < N_WORDS; i++)
      readWord(i, ANY_STALL);

    // Both caches on, random translation base
    ctrl  = randBits(32) | 32'h0000_1004;
    tBase = randBits(32);
    cpWrite(REG_CONTROL, 4'd0, ctrl);
    cpWrite(REG_TBASE, 4'd0, tBase);
    cpRead(REG_CONTROL, got);
    checkWord("cpRd", got, ctrl);
    cpRead(REG_TBASE, got);
    checkWord("cpRd", got, tBase);
    cpRead(REG_ID, got);
    checkWord("cpRd", got, `CP15_ID);

    for (int i = 0; i < N_HOT; i++)
    begin
      readWord(i, ANY_STALL);
      readWord(i, NO_STALL);
      m = randBits(4);
      writeWord(i, randBits(32), m[3:0]);
      readWord(i, NO_STALL);
    end

    cpWrite(REG_CACHEOP, OP_INV_D, 32'd0);
    for (int i = 0; i < N_HOT; i++)
      readWord(i, MUST_STALL);

    for (int i = 0; i < N_HOT; i++)
    begin
      fetchWord(i, ANY_STALL);
      fetchWord(i, NO_STALL);
    end
    cpWrite(REG_CACHEOP, OP_INV_I, 32'd0);
    fetchWord(0, MUST_STALL);

    // Both sides miss and compete for the bus
    cpWrite(REG_CACHEOP, OP_INV_BOTH, 32'd0);
    for (int i = 0; i < N_HOT; i++)
      dualAccess(i, N_HOT + i, i[0]);

    // Words written beside a fetch read back from memory
    for (int i = 1; i < N_HOT; i += 2)
      readWord(N_HOT + i, ANY_STALL);

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, memsysTop_i.memsysAssert_i.failCount);
    if (errors == 0 && memsysTop_i.memsysAssert_i.failCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, a stall never ended", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
memsysPkg.sv
sysControl.sv
instrCache.sv
dataCache.sv
busArbiter.sv
busMemory.sv
memsysTop.sv
memsys_assert.sv
memsysTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the memory system testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --no-stop-fail -Wno-fatal --top-module memsysTb \
  -f project.f -o memsysSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/memsysSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
